//--- sim.f
design/core_pkg.sv
design/mem_arbiter.sv
design/fetch_unit.sv
design/register_file.sv
design/load_store_unit.sv
design/decode_execute.sv
design/mini_core.sv
sim/mini_core_chk.sv
sim/tb_mini_core.sv

//--- Makefile
# Verilator build and run for mini_core

VERILATOR ?= verilator
TOP       ?= tb_mini_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q '^=== PASS ===$$' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_mini_core.sv
// Testbench for mini_core: random RV32I subset program, memory model and ISA model
// Instruction words come from an LFSR on first fetch; every retire record is checked
`timescale 1ns/100ps
`default_nettype none

module tb_mini_core
    import core_pkg::*;
;

    localparam int rsp_depth   = mem_latency;
    localparam int num_retire  = 300;
    localparam int stall_limit = 200;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     mem_req_valid;
    mem_req_t mem_req;
    logic     mem_rsp_valid;
    mem_rsp_t mem_rsp;
    logic     retire_valid;
    retire_t  retire;

    logic [31:0] lfsr;
    word_t       imem [512];
    bit          imem_gen [512];
    word_t       dmem [64];
    word_t       ref_regs [32];
    word_t       ref_data [64];
    word_t       ref_pc;
    int          retired;
    int          wait_cycles;
    int          fetch_reqs;
    int          data_reqs;
    logic        stage_valid [rsp_depth];
    mem_rsp_t    stage_rsp [rsp_depth];

    always #5 clk = ~clk;

    mini_core #(
        .reset_pc (32'h0)
    ) i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .retire_valid  (retire_valid),
        .retire        (retire)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_equal(input word_t got, input word_t exp, input string what);
        assert (got == exp)
            else abort_run($sformatf("Fail at %0t ns: %s is %h, expected %h (pc %h)",
                                     $time, what, got, exp, ref_pc));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Random program generation
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        // Galois LFSR, one step per bit
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic word_t gen_inst();
        logic [31:0] k;
        logic [31:0] r;
        k = rand_bits(3);
        case (k[2:0])
            3'd0: begin
                r = rand_bits(15);
                return {7'b0000000, r[14:10], r[9:5], 3'b000, r[4:0], 7'b0110011};
            end
            3'd1: begin
                r = rand_bits(15);
                return {7'b0100000, r[14:10], r[9:5], 3'b000, r[4:0], 7'b0110011};
            end
            3'd2: begin
                r = rand_bits(15);
                return {7'b0000000, r[14:10], r[9:5], 3'b111, r[4:0], 7'b0110011};
            end
            3'd3: begin
                r = rand_bits(15);
                return {7'b0000000, r[14:10], r[9:5], 3'b110, r[4:0], 7'b0110011};
            end
            3'd4: begin
                r = rand_bits(15);
                return {7'b0000000, r[14:10], r[9:5], 3'b100, r[4:0], 7'b0110011};
            end
            3'd5: begin
                r = rand_bits(22);
                return {r[21:10], r[9:5], 3'b000, r[4:0], 7'b0010011};
            end
            // LW and SW: base x0, word offset into the data region at 0x400
            3'd6: begin
                r = rand_bits(11);
                return {4'b0100, r[10:5], 2'b00, 5'd0, 3'b010, r[4:0], 7'b0000011};
            end
            default: begin
                r = rand_bits(11);
                return {4'b0100, r[10:8], r[4:0], 5'd0, 3'b010, r[7:5], 2'b00, 7'b0100011};
            end
        endcase
    endfunction

    function automatic word_t inst_at(input word_t addr);
        if (!imem_gen[addr[10:2]]) begin
            imem[addr[10:2]]     = gen_inst();
            imem_gen[addr[10:2]] = 1'b1;
        end
        return imem[addr[10:2]];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Memory model, fetches and data accesses served from separate stores
    task automatic serve_request();
        mem_rsp_t rsp;
        if (mem_req.tag == REQ_FETCH) begin
            fetch_reqs++;
            assert (mem_req.addr < 32'h800)
                else abort_run("instruction fetch outside the instruction region");
            rsp.rdata = inst_at(mem_req.addr);
        end else begin
            data_reqs++;
            assert (mem_req.addr[31:8] == 24'h000004)
                else abort_run("data access outside the data region");
            if (mem_req.write)
                dmem[mem_req.addr[7:2]] = mem_req.wdata;
            rsp.rdata = dmem[mem_req.addr[7:2]];
        end
        rsp.tag        = mem_req.tag;
        stage_valid[0] = !mem_req.write;
        stage_rsp[0]   = rsp;
    endtask

    // Port is stable mid-cycle
    always @(negedge clk) begin
        if (rst_n && mem_req_valid)
            serve_request();
    end

    always @(posedge clk) begin
        #1;
        mem_rsp_valid = stage_valid[rsp_depth-1];
        mem_rsp       = stage_rsp[rsp_depth-1];
        for (int i = rsp_depth - 1; i > 0; i--) begin
            stage_valid[i] = stage_valid[i-1];
            stage_rsp[i]   = stage_rsp[i-1];
        end
        stage_valid[0] = 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // ISA model, run once per retire record in program order
    task automatic check_retire();
        word_t inst;
        word_t a;
        word_t b;
        word_t imm_i;
        word_t imm_s;
        word_t addr;
        word_t exp_val;
        logic  exp_we;
        inst    = inst_at(ref_pc);
        a       = ref_regs[inst[19:15]];
        b       = ref_regs[inst[24:20]];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        exp_we  = 1'b1;
        exp_val = '0;
        case (inst[6:0])
            7'b0110011: begin
                case (inst[14:12])
                    3'b100:  exp_val = a ^ b;
                    3'b110:  exp_val = a | b;
                    3'b111:  exp_val = a & b;
                    default: exp_val = inst[30] ? a - b : a + b;
                endcase
            end
            7'b0010011: exp_val = a + imm_i;
            7'b0000011: begin
                addr    = a + imm_i;
                exp_val = ref_data[addr[7:2]];
            end
            default: begin
                addr                = a + imm_s;
                ref_data[addr[7:2]] = b;
                exp_we              = 1'b0;
            end
        endcase
        if (inst[11:7] == 5'd0)
            exp_val = '0;
        check_equal(retire.pc, ref_pc, "retired pc");
        check_equal(retire.inst, inst, "retired instruction");
        check_equal(32'(retire.rd), 32'(inst[11:7]), "retired rd");
        check_equal(32'(retire.we), 32'(exp_we), "retired write enable");
        check_equal(retire.value, exp_val, "retired value");
        if (exp_we && inst[11:7] != 5'd0)
            ref_regs[inst[11:7]] = exp_val;
        ref_pc = ref_pc + 32'd4;
    endtask

    initial begin
        rst_n         = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        lfsr          = 32'hc380;
        ref_pc        = 32'h0;
        retired       = 0;
        fetch_reqs    = 0;
        data_reqs     = 0;
        stage_valid   = '{default: 1'b0};
        stage_rsp     = '{default: '0};
        for (int i = 0; i < 64; i++) begin
            dmem[i]     = '0;
            ref_data[i] = '0;
        end
        for (int i = 0; i < 32; i++)
            ref_regs[i] = '0;

        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #1;
            assert (!retire_valid && !mem_req_valid)
                else abort_run("strobe seen on the retire or memory port during reset");
        end
        rst_n = 1'b1;

        while (retired < num_retire) begin
            wait_cycles = 0;
            do begin
                @(negedge clk);
                wait_cycles++;
            end while (!retire_valid && wait_cycles < stall_limit);
            assert (retire_valid)
                else abort_run("no instruction retired for 200 cycles, the core has stalled");
            check_retire();
            retired++;
        end

        assert (fetch_reqs > 0 && data_reqs > 0)
            else abort_run("the run did not see both fetch and data traffic");
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/mini_core_chk.sv
// Protocol checks on the shared memory port, bound into every mem_arbiter
`timescale 1ns/100ps
`default_nettype none

module mini_core_chk
    import core_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     data_req_valid,
    input logic     mem_req_valid,
    input mem_req_t mem_req,
    input logic     mem_rsp_valid,
    input mem_rsp_t mem_rsp
);

    logic [1:0] fetch_open;
    logic [1:0] data_open;
    logic       read_fetch;
    logic       read_data;
    logic       rsp_fetch;
    logic       rsp_data;

    assign read_fetch = mem_req_valid && !mem_req.write && (mem_req.tag == REQ_FETCH);
    assign read_data  = mem_req_valid && !mem_req.write && (mem_req.tag == REQ_DATA);
    assign rsp_fetch  = mem_rsp_valid && (mem_rsp.tag == REQ_FETCH);
    assign rsp_data   = mem_rsp_valid && (mem_rsp.tag == REQ_DATA);

    // Reads in flight per peer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_open <= '0;
            data_open  <= '0;
        end else begin
            fetch_open <= fetch_open + {1'b0, read_fetch} - {1'b0, rsp_fetch};
            data_open  <= data_open + {1'b0, read_data} - {1'b0, rsp_data};
        end
    end

    //////////////////////////////////////////////////////////////////////
    data_next: assert property (@(posedge clk) disable iff (!rst_n)
        data_req_valid |=> (mem_req_valid && (mem_req.tag == REQ_DATA)))
        else $error("data request did not reach the memory port in the next cycle");

    rsp_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_valid && !mem_req.write) |-> ##mem_latency
            (mem_rsp_valid && (mem_rsp.tag == $past(mem_req.tag, mem_latency))))
        else $error("read response missing or late");

    fetch_owner: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_fetch |-> (fetch_open != '0))
        else $error("fetch response with no fetch outstanding");

    data_owner: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_data |-> (data_open != '0))
        else $error("data response with no load outstanding");

endmodule

bind mem_arbiter mini_core_chk i_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_valid (data_req_valid),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_rsp_valid  (mem_rsp_valid),
    .mem_rsp        (mem_rsp)
);

`default_nettype wire

//--- design/mini_core.sv
// Top level of the RV32I subset core; one memory port and a retire trace
`timescale 1ns/100ps
`default_nettype none

module mini_core
    import core_pkg::*;
#(
    parameter word_t reset_pc = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    output logic     mem_req_valid,
    output mem_req_t mem_req,
    input  logic     mem_rsp_valid,
    input  mem_rsp_t mem_rsp,
    output logic     retire_valid,
    output retire_t  retire
);

    logic      fetch_req_valid;
    word_t     fetch_addr;
    logic      fetch_rsp_valid;
    word_t     fetch_rdata;
    logic      data_req_valid;
    mem_req_t  data_req;
    logic      data_rsp_valid;
    word_t     data_rdata;
    logic      inst_valid;
    word_t     inst_word;
    word_t     inst_pc;
    logic      inst_take;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;
    logic      ls_valid;
    word_t     ls_addr;
    word_t     ls_wdata;
    logic      ls_write;
    reg_addr_t ls_rd;
    logic      load_done;
    reg_addr_t load_rd;
    word_t     load_data;

    //////////////////////////////////////////////////////////////////////
    // Memory port
    mem_arbiter i_arbiter (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_req_valid (fetch_req_valid),
        .fetch_addr      (fetch_addr),
        .data_req_valid  (data_req_valid),
        .data_req        (data_req),
        .mem_req_valid   (mem_req_valid),
        .mem_req         (mem_req),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp         (mem_rsp),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rdata     (fetch_rdata),
        .data_rsp_valid  (data_rsp_valid),
        .data_rdata      (data_rdata)
    );

    //////////////////////////////////////////////////////////////////////
    // Fetch
    fetch_unit #(
        .reset_pc (reset_pc)
    ) i_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_req_valid (fetch_req_valid),
        .fetch_addr      (fetch_addr),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rdata     (fetch_rdata),
        .inst_valid      (inst_valid),
        .inst_word       (inst_word),
        .inst_pc         (inst_pc),
        .inst_take       (inst_take)
    );

    //////////////////////////////////////////////////////////////////////
    // Execute, registers and load/store
    decode_execute i_decode_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst_word    (inst_word),
        .inst_pc      (inst_pc),
        .inst_take    (inst_take),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .ls_valid     (ls_valid),
        .ls_addr      (ls_addr),
        .ls_wdata     (ls_wdata),
        .ls_write     (ls_write),
        .ls_rd        (ls_rd),
        .load_done    (load_done),
        .load_rd      (load_rd),
        .load_data    (load_data),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    register_file i_register_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    load_store_unit i_load_store (
        .clk            (clk),
        .rst_n          (rst_n),
        .ls_valid       (ls_valid),
        .ls_addr        (ls_addr),
        .ls_wdata       (ls_wdata),
        .ls_write       (ls_write),
        .ls_rd          (ls_rd),
        .data_req_valid (data_req_valid),
        .data_req       (data_req),
        .data_rsp_valid (data_rsp_valid),
        .data_rdata     (data_rdata),
        .load_done      (load_done),
        .load_rd        (load_rd),
        .load_data      (load_data)
    );

endmodule

`default_nettype wire

//--- design/decode_execute.sv
// Decode, ALU and the instruction sequencer of the core
// Executes one instruction at a time and emits a retire record for each
`timescale 1ns/100ps
`default_nettype none

module decode_execute
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      inst_valid,
    input  word_t     inst_word,
    input  word_t     inst_pc,
    output logic      inst_take,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    output logic      wr_en,
    output reg_addr_t wr_addr,
    output word_t     wr_data,
    output logic      ls_valid,
    output word_t     ls_addr,
    output word_t     ls_wdata,
    output logic      ls_write,
    output reg_addr_t ls_rd,
    input  logic      load_done,
    input  reg_addr_t load_rd,
    input  word_t     load_data,
    output logic      retire_valid,
    output retire_t   retire
);

    typedef enum logic [1:0] {
        IDLE,
        EXECUTE,
        WAIT_LOAD
    } state_e;

    state_e    state;
    word_t     inst_q;
    word_t     pc_q;
    logic      load_ret;
    word_t     load_q;
    opcode_e   opcode;
    alu_op_e   alu_op;
    reg_addr_t rd;
    word_t     imm_i;
    word_t     imm_s;
    word_t     alu_b;
    word_t     alu_res;
    logic      is_alu;
    logic      wb_load;

    //////////////////////////////////////////////////////////////////////
    // Sequencer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            load_ret <= 1'b0;
        end else begin
            load_ret <= wb_load;
            case (state)
                IDLE:      state <= inst_take ? EXECUTE : IDLE;
                EXECUTE:   state <= (opcode == LOAD) ? WAIT_LOAD : IDLE;
                WAIT_LOAD: state <= load_done ? IDLE : WAIT_LOAD;
                default:   state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (inst_take) begin
            inst_q <= inst_word;
            pc_q   <= inst_pc;
        end
        if (wb_load)
            load_q <= load_data;
    end

    assign inst_take = (state == IDLE) && inst_valid;

    //////////////////////////////////////////////////////////////////////
    // Decode and ALU
    assign opcode   = opcode_e'(inst_q[6:0]);
    assign rd       = inst_q[11:7];
    assign rs1_addr = inst_q[19:15];
    assign rs2_addr = inst_q[24:20];
    assign imm_i    = {{20{inst_q[31]}}, inst_q[31:20]};
    assign imm_s    = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
    assign is_alu   = (opcode == OP) || (opcode == OP_IMM);

    always_comb begin
        case (inst_q[14:12])
            3'b100:  alu_op = ALU_XOR;
            3'b110:  alu_op = ALU_OR;
            3'b111:  alu_op = ALU_AND;
            // funct7 bit 5 only means SUB for register-register ops
            default: alu_op = (opcode == OP && inst_q[30]) ? ALU_SUB : ALU_ADD;
        endcase
    end

    assign alu_b = (opcode == OP) ? rs2_data : imm_i;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_res = rs1_data - alu_b;
            ALU_AND: alu_res = rs1_data & alu_b;
            ALU_OR:  alu_res = rs1_data | alu_b;
            ALU_XOR: alu_res = rs1_data ^ alu_b;
            default: alu_res = rs1_data + alu_b;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Writeback, memory issue and retire
    assign wb_load = (state == WAIT_LOAD) && load_done;
    assign wr_en   = ((state == EXECUTE) && is_alu) || wb_load;
    assign wr_addr = wb_load ? load_rd : rd;
    assign wr_data = wb_load ? load_data : alu_res;

    assign ls_valid = (state == EXECUTE) && ((opcode == LOAD) || (opcode == STORE));
    assign ls_addr  = rs1_data + ((opcode == STORE) ? imm_s : imm_i);
    assign ls_wdata = rs2_data;
    assign ls_write = (opcode == STORE);
    assign ls_rd    = rd;

    // Loads retire the cycle after their data is written back
    assign retire_valid = ((state == EXECUTE) && (opcode != LOAD)) || load_ret;

    always_comb begin
        retire.pc   = pc_q;
        retire.inst = inst_q;
        retire.rd   = rd;
        retire.we   = load_ret || is_alu;
        if (!retire.we || rd == '0)
            retire.value = '0;
        else if (load_ret)
            retire.value = load_q;
        else
            retire.value = alu_res;
    end

endmodule

`default_nettype wire

//--- design/load_store_unit.sv
// Turns LW/SW issues into word-aligned data bus requests
// Tracks the single outstanding load and hands back its data and rd
`timescale 1ns/100ps
`default_nettype none

module load_store_unit
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      ls_valid,
    input  word_t     ls_addr,
    input  word_t     ls_wdata,
    input  logic      ls_write,
    input  reg_addr_t ls_rd,
    output logic      data_req_valid,
    output mem_req_t  data_req,
    input  logic      data_rsp_valid,
    input  word_t     data_rdata,
    output logic      load_done,
    output reg_addr_t load_rd,
    output word_t     load_data
);

    logic      load_pend;
    reg_addr_t rd_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            load_pend <= 1'b0;
        else if (ls_valid && !ls_write)
            load_pend <= 1'b1;
        else if (data_rsp_valid)
            load_pend <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (ls_valid && !ls_write)
            rd_q <= ls_rd;
    end

    //////////////////////////////////////////////////////////////////////
    // Bus request, stores are posted
    assign data_req_valid = ls_valid;
    assign data_req.addr  = {ls_addr[xlen-1:2], 2'b00};
    assign data_req.wdata = ls_wdata;
    assign data_req.write = ls_write;
    assign data_req.tag   = REQ_DATA;

    assign load_done = data_rsp_valid && load_pend;
    assign load_rd   = rd_q;
    assign load_data = data_rdata;

endmodule

`default_nettype wire

//--- design/register_file.sv
// Integer register file, two asynchronous read ports and one write port
`timescale 1ns/100ps
`default_nettype none

module register_file
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // x0 is hardwired
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- design/fetch_unit.sv
// Sequential instruction fetch with a one-entry prefetch buffer
// A new fetch goes out as soon as the buffer is empty or being emptied
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
    import core_pkg::*;
#(
    parameter word_t reset_pc = '0
) (
    input  logic  clk,
    input  logic  rst_n,
    output logic  fetch_req_valid,
    output word_t fetch_addr,
    input  logic  fetch_rsp_valid,
    input  word_t fetch_rdata,
    output logic  inst_valid,
    output word_t inst_word,
    output word_t inst_pc,
    input  logic  inst_take
);

    word_t fetch_pc;
    logic  outstanding;

    // Outstanding implies the buffer is empty, so one flag covers room
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pc        <= reset_pc;
            outstanding     <= 1'b0;
            fetch_req_valid <= 1'b0;
            inst_valid      <= 1'b0;
        end else begin
            fetch_req_valid <= !outstanding && !fetch_req_valid &&
                               (!inst_valid || inst_take);
            if (fetch_req_valid)
                outstanding <= 1'b1;
            else if (fetch_rsp_valid)
                outstanding <= 1'b0;

            if (fetch_rsp_valid) begin
                inst_valid <= 1'b1;
                fetch_pc   <= fetch_pc + 32'd4;
            end else if (inst_take) begin
                inst_valid <= 1'b0;
            end
        end
    end

    // Instruction buffer payload
    always_ff @(posedge clk) begin
        if (fetch_rsp_valid) begin
            inst_word <= fetch_rdata;
            inst_pc   <= fetch_pc;
        end
    end

    assign fetch_addr = fetch_pc;

endmodule

`default_nettype wire

//--- design/mem_arbiter.sv
// Merges the fetch and data requesters onto the single memory port
// Data requests win; each peer has one pending slot, responses return by tag
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fetch_req_valid,
    input  word_t    fetch_addr,
    input  logic     data_req_valid,
    input  mem_req_t data_req,
    output logic     mem_req_valid,
    output mem_req_t mem_req,
    input  logic     mem_rsp_valid,
    input  mem_rsp_t mem_rsp,
    output logic     fetch_rsp_valid,
    output word_t    fetch_rdata,
    output logic     data_rsp_valid,
    output word_t    data_rdata
);

    logic     fetch_pend;
    word_t    fetch_pend_addr;
    logic     data_pend;
    mem_req_t data_pend_req;

    //////////////////////////////////////////////////////////////////////
    // Pending slots
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pend <= 1'b0;
            data_pend  <= 1'b0;
        end else begin
            // Data has priority, so its slot drains the cycle after capture
            data_pend <= data_req_valid;
            if (fetch_req_valid)
                fetch_pend <= 1'b1;
            else if (!data_pend)
                fetch_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_req_valid)
            fetch_pend_addr <= fetch_addr;
        if (data_req_valid)
            data_pend_req <= data_req;
    end

    //////////////////////////////////////////////////////////////////////
    // Shared port and response steering
    always_comb begin
        mem_req_valid = data_pend | fetch_pend;
        if (data_pend) begin
            mem_req     = data_pend_req;
            mem_req.tag = REQ_DATA;
        end else begin
            mem_req.addr  = fetch_pend_addr;
            mem_req.wdata = '0;
            mem_req.write = 1'b0;
            mem_req.tag   = REQ_FETCH;
        end
    end

    assign fetch_rsp_valid = mem_rsp_valid && (mem_rsp.tag == REQ_FETCH);
    assign fetch_rdata     = mem_rsp.rdata;
    assign data_rsp_valid  = mem_rsp_valid && (mem_rsp.tag == REQ_DATA);
    assign data_rdata      = mem_rsp.rdata;

endmodule

`default_nettype wire

//--- design/core_pkg.sv
// Shared widths, opcode encodings and bus/trace payload structs for mini_core
// Imported by every core module that moves words or decodes instructions
`default_nettype none

package core_pkg;

    localparam int xlen = 32;

    // Read response comes back this many cycles after the request strobe
    localparam int mem_latency = 2;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // RV32I major opcodes used by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    // Bus tag, selects which peer a response belongs to
    typedef enum logic {
        REQ_FETCH = 1'b0,
        REQ_DATA  = 1'b1
    } requester_e;

    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        logic       write;
        requester_e tag;
    } mem_req_t;

    typedef struct packed {
        word_t      rdata;
        requester_e tag;
    } mem_rsp_t;

    // One record per retired instruction
    typedef struct packed {
        word_t     pc;
        word_t     inst;
        reg_addr_t rd;
        logic      we;
        word_t     value;
    } retire_t;

endpackage

`default_nettype wire
